//--- verilog.f
cpuPkg.sv
programCounter.sv
alu.sv
registerFile.sv
datapath.sv
control.sv
cpuCore.sv
cpuCore_assertions.sv
cpuCoreTb.sv

//--- Makefile
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb -f verilog.f -o cpuCoreSim

run: compile
	./obj_dir/cpuCoreSim | tee $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- cpuCoreTb.sv
// Testbench for cpuCore with clock, reset, wait-state memory model, program table and checks
`default_nettype none
`timescale 1ns/100ps

module cpuCoreTb;

  import cpuPkg::*;

  localparam int         TestCount     = 12;
  localparam int         Timeout       = 400;    // Cycles allowed per wait loop
  localparam logic [5:0] MarkerAddress = 6'h3e;  // Written only by an untaken branch

  typedef struct packed {
    opcode_t     op;
    logic [5:0]  a;
    logic [5:0]  b;
    logic [5:0]  address;
    logic [15:0] expected;
  } testRow_t;

  // LOAD rows preset mem[a] with the expected word
  testRow_t tests [TestCount] = '{
    '{ADD,  6'h2f, 6'h31, 6'h20, 16'h0060},
    '{SUB,  6'h05, 6'h09, 6'h21, 16'hfffc},
    '{AND,  6'h3c, 6'h27, 6'h22, 16'h0024},
    '{OR,   6'h12, 6'h21, 6'h23, 16'h0033},
    '{XOR,  6'h3f, 6'h15, 6'h24, 16'h002a},
    '{LOAD, 6'h30, 6'h00, 6'h25, 16'hbeef},
    '{BRZ,  6'h1a, 6'h1a, 6'h26, 16'h0000},  // Taken
    '{BRZ,  6'h20, 6'h07, 6'h27, 16'h0019},  // Not taken
    '{JMP,  6'h09, 6'h03, 6'h28, 16'h0006},
    '{ADD,  6'h3f, 6'h3f, 6'h29, 16'h007e},
    '{SUB,  6'h30, 6'h30, 6'h2a, 16'h0000},
    '{SUB,  6'h00, 6'h3f, 6'h2b, 16'hffc1}   // Borrow
  };

  logic        Clock;
  logic        reset;
  logic [15:0] dataIn;
  logic        nWait;
  logic [15:0] dataOut;
  logic        ale;
  logic        nME;
  logic        nOE;
  logic        rnW;

  logic [15:0] memory [256];
  logic [15:0] busAddress;
  logic [15:0] sampledData;
  logic        sampledAle;
  logic        sampledRnw;
  logic        sampledNoe;
  bit          inAccess = 1'b0;
  int          waitLeft = 0;
  bit          randomWaits = 1'b0;
  logic [31:0] lfsr = 32'hb7c37796;
  int          writeCount = 0;
  logic [15:0] lastWriteAddress = '0;
  logic [15:0] lastWriteData = '0;
  int          errorCount = 0;
  int          testsRun = 0;
  int          testsFailed = 0;

  cpuCore #(
    .WordWidth (WORD_WIDTH)
  ) u_cpuCore (
    .Clock   (Clock),
    .reset   (reset),
    .dataIn  (dataIn),
    .nWait   (nWait),
    .dataOut (dataOut),
    .ale     (ale),
    .nME     (nME),
    .nOE     (nOE),
    .rnW     (rnW)
  );

  always #2 Clock = ~Clock;

  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic int drawWaitCycles();
    int count;
    count = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr  = nextLfsr(lfsr);
      count = (count << 1) | int'(lfsr[0]);
    end
    return count;
  endfunction

  function automatic logic [15:0] fillValue(input logic [7:0] address);
    return {address ^ 8'hc3, ~address};
  endfunction

  function automatic logic [15:0] encodeMovi(input logic [1:0] rd, input logic [5:0] value);
    return {MOVI, rd, value};
  endfunction

  function automatic logic [15:0] encodeRegOp(input opcode_t op, input logic [1:0] rd,
                                              input logic [1:0] rs);
    return {op, rd, rs, 4'h0};
  endfunction

  // Bus sampled mid-cycle, acted on just after the next rising edge
  always @(negedge Clock) begin
    sampledData = dataOut;
    sampledAle  = ale;
    sampledRnw  = rnW;
    sampledNoe  = nOE;
  end

  always @(posedge Clock) begin
    #0.5;
    if (sampledAle === 1'b1)
      busAddress = sampledData;
    if (inAccess && nWait) begin  // Edge just passed completed the access
      if (sampledRnw === 1'b0) begin
        compareValue("nOE", 16'(sampledNoe), 16'h0001);  // Memory output off for a write
        memory[busAddress[7:0]] = sampledData;
        lastWriteAddress = busAddress;
        lastWriteData    = sampledData;
        writeCount++;
      end else begin
        compareValue("nOE", 16'(sampledNoe), 16'h0000);
      end
      inAccess = 1'b0;
    end
    if (nME === 1'b0 && !inAccess) begin
      inAccess = 1'b1;
      waitLeft = randomWaits ? drawWaitCycles() : 0;
      dataIn   = memory[busAddress[7:0]];
    end else if (inAccess) begin
      waitLeft--;
    end
    nWait = !inAccess || (waitLeft == 0);
  end

  task automatic compareValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic loadProgram(input testRow_t row);
    for (int i = 0; i < 256; i++)
      memory[i] = fillValue(8'(i));
    memory[0] = encodeMovi(2'd0, row.a);
    memory[1] = encodeMovi(2'd1, row.b);
    case (row.op)
      BRZ, JMP: begin
        memory[2] = encodeRegOp(SUB, 2'd0, 2'd1);
        memory[3] = encodeMovi(2'd2, row.address);
        memory[4] = encodeMovi(2'd3, MarkerAddress);
        memory[5] = {row.op, 2'd0, 6'd1};           // Skips the marker store
        memory[6] = encodeRegOp(STORE, 2'd2, 2'd3);
        memory[7] = encodeRegOp(STORE, 2'd0, 2'd2);
        memory[8] = {HALT, 8'h00};
      end
      LOAD: begin
        memory[row.a] = row.expected;
        memory[0] = encodeMovi(2'd1, row.a);
        memory[1] = encodeRegOp(LOAD, 2'd0, 2'd1);
        memory[2] = encodeMovi(2'd2, row.address);
        memory[3] = encodeRegOp(STORE, 2'd0, 2'd2);
        memory[4] = {HALT, 8'h00};
      end
      default: begin
        memory[2] = encodeRegOp(row.op, 2'd0, 2'd1);
        memory[3] = encodeMovi(2'd2, row.address);
        memory[4] = encodeRegOp(STORE, 2'd0, 2'd2);
        memory[5] = {HALT, 8'h00};
      end
    endcase
  endtask

  task automatic resetCore();
    @(posedge Clock);
    #0.5;
    reset = 1'b1;
    repeat (15) @(posedge Clock);
    @(negedge Clock);
    compareValue("ale", 16'(ale), 16'h0000);
    compareValue("nME", 16'(nME), 16'h0001);
    compareValue("nOE", 16'(nOE), 16'h0001);
    compareValue("rnW", 16'(rnW), 16'h0001);
    @(posedge Clock);
    #0.5;
    reset = 1'b0;
  endtask

  task automatic runTest(input int index, output bit ok);
    testRow_t    row;
    int          errorsBefore;
    int          writesBefore;
    int          cycles;
    int          aleCount;
    int          quiet;
    int          activity;
    logic [15:0] markerValue;
    row          = tests[index];
    errorsBefore = errorCount;
    ok           = 1'b1;
    loadProgram(row);
    writesBefore = writeCount;
    resetCore();
    cycles = 0;
    while (ale !== 1'b1 && cycles < Timeout) begin
      @(negedge Clock);
      cycles++;
    end
    if (ale !== 1'b1) begin
      $display("Timeout: no instruction fetch after reset in test %0d", index);
      ok = 1'b0;
    end else begin
      compareValue("dataOut", dataOut, 16'h0000);  // First fetch address
    end
    cycles = 0;
    while (ok && (writeCount == writesBefore || lastWriteAddress == 16'(MarkerAddress))
           && cycles < Timeout) begin
      @(negedge Clock);
      cycles++;
    end
    if (ok && cycles >= Timeout) begin
      $display("Timeout: result store never reached memory in test %0d", index);
      ok = 1'b0;
    end
    if (ok) begin
      compareValue("write address", lastWriteAddress, 16'(row.address));
      compareValue("write data", lastWriteData, row.expected);
      aleCount = (ale === 1'b1) ? 1 : 0;  // HALT fetch may already be on the bus
      quiet    = 0;
      cycles   = 0;
      while (quiet < 4 && cycles < Timeout) begin
        @(negedge Clock);
        cycles++;
        if (ale === 1'b1)
          aleCount++;
        quiet = (ale !== 1'b0 || nME !== 1'b1) ? 0 : quiet + 1;
      end
      if (quiet < 4) begin
        $display("Timeout: core did not halt in test %0d", index);
        ok = 1'b0;
      end else begin
        compareValue("fetches after store", 16'(aleCount), 16'h0001);
        activity = 0;
        repeat (40) begin
          @(negedge Clock);
          if (ale !== 1'b0 || nME !== 1'b1)
            activity++;
        end
        if (activity != 0) begin
          $display("Bus activity after HALT in test %0d", index);
          errorCount++;
        end
        markerValue = (row.op == BRZ && row.a != row.b) ? 16'(row.address)
                                                        : fillValue(8'(MarkerAddress));
        compareValue("marker word", memory[MarkerAddress], markerValue);
      end
    end
    testsRun++;
    if (!ok || errorCount != errorsBefore)
      testsFailed++;
    $display("Test %0d %s with %s waits: %s", index, row.op.name(),
             randomWaits ? "random" : "no",
             (ok && errorCount == errorsBefore) ? "passed" : "failed");
  endtask

  initial begin
    bit ok;
    Clock  = 1'b0;
    reset  = 1'b1;
    dataIn = '0;
    nWait  = 1'b1;
    ok     = 1'b1;
    for (int pass = 0; pass < 2 && ok; pass++) begin
      randomWaits = (pass == 1);
      for (int i = 0; i < TestCount && ok; i++)
        runTest(i, ok);
    end
    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
    if (ok && errorCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpuCore_assertions.sv
// Concurrent assertions on the memory bus strobes, bound into cpuCore
`default_nettype none
`timescale 1ns/100ps

module cpuCoreAssertions (
  input logic                  Clock,
  input logic                  reset,
  input logic                  ale,
  input logic                  nME,
  input logic                  nOE,
  input logic                  rnW,
  input cpuPkg::controlState_t state
);

  import cpuPkg::*;

  // Address and access phases never overlap
  assert property (@(posedge Clock) disable iff (reset) !(ale && !nME))
    else $error("ale high during an access");

  assert property (@(posedge Clock) disable iff (reset) !rnW |-> !nME)
    else $error("rnW low outside an access");

  assert property (@(posedge Clock) disable iff (reset) $fell(nME) |-> $past(ale))
    else $error("access started without an address cycle");

  assert property (@(posedge Clock) reset |=> (!ale && nME && nOE && rnW))
    else $error("bus strobes active during reset");

  assert property (@(posedge Clock) disable iff (reset) (state == HALTED) |-> (!ale && nME))
    else $error("bus activity while halted");  // Parked until reset

endmodule

bind cpuCore cpuCoreAssertions u_cpuCoreAssertions (
  .Clock (Clock),
  .reset (reset),
  .ale   (ale),
  .nME   (nME),
  .nOE   (nOE),
  .rnW   (rnW),
  .state (u_control.state)
);

`default_nettype wire

//--- cpuCore.sv
// Core top level joining control and datapath to the multiplexed memory bus
`default_nettype none
`timescale 1ns/100ps

module cpuCore #(
  parameter int                   WordWidth    = cpuPkg::WORD_WIDTH,
  parameter logic [WordWidth-1:0] ResetAddress = '0
) (
  input  logic                 Clock,
  input  logic                 reset,
  input  logic [WordWidth-1:0] dataIn,
  input  logic                 nWait,
  output logic [WordWidth-1:0] dataOut,  // Address on ale, else write data
  output logic                 ale,
  output logic                 nME,
  output logic                 nOE,
  output logic                 rnW
);

  import cpuPkg::*;

  aluFunction_t aluFunction;
  opcode_t      opcode;
  logic         op2Sel;
  logic         irWe;
  logic         pcIncrement;
  logic         pcLoad;
  logic         regWe;
  logic         wdSel;
  logic         flagWe;
  logic         addrSel;
  logic         busDataSel;
  logic         zeroFlag;

  control u_control (
    .Clock       (Clock),
    .reset       (reset),
    .opcode      (opcode),
    .zeroFlag    (zeroFlag),
    .nWait       (nWait),
    .aluFunction (aluFunction),
    .op2Sel      (op2Sel),
    .irWe        (irWe),
    .pcIncrement (pcIncrement),
    .pcLoad      (pcLoad),
    .regWe       (regWe),
    .wdSel       (wdSel),
    .flagWe      (flagWe),
    .addrSel     (addrSel),
    .busDataSel  (busDataSel),
    .ale         (ale),
    .nME         (nME),
    .nOE         (nOE),
    .rnW         (rnW)
  );

  datapath #(
    .WordWidth    (WordWidth),
    .ResetAddress (ResetAddress)
  ) u_datapath (
    .Clock       (Clock),
    .reset       (reset),
    .aluFunction (aluFunction),
    .op2Sel      (op2Sel),
    .irWe        (irWe),
    .pcIncrement (pcIncrement),
    .pcLoad      (pcLoad),
    .regWe       (regWe),
    .wdSel       (wdSel),
    .flagWe      (flagWe),
    .addrSel     (addrSel),
    .busDataSel  (busDataSel),
    .dataIn      (dataIn),
    .opcode      (opcode),
    .zeroFlag    (zeroFlag),
    .dataOut     (dataOut)
  );

endmodule

`default_nettype wire

//--- control.sv
// Control FSM sequencing memory cycles and instructions, with registered bus strobes
`default_nettype none
`timescale 1ns/100ps

module control (
  input  logic                 Clock,
  input  logic                 reset,
  input  cpuPkg::opcode_t      opcode,
  input  logic                 zeroFlag,
  input  logic                 nWait,
  output cpuPkg::aluFunction_t aluFunction,
  output logic                 op2Sel,
  output logic                 irWe,
  output logic                 pcIncrement,
  output logic                 pcLoad,
  output logic                 regWe,
  output logic                 wdSel,
  output logic                 flagWe,
  output logic                 addrSel,
  output logic                 busDataSel,
  output logic                 ale,
  output logic                 nME,
  output logic                 nOE,
  output logic                 rnW
);

  import cpuPkg::*;

  controlState_t state;
  controlState_t nextState;
  logic          isRegisterOp;

  assign isRegisterOp = opcode inside {ADD, SUB, AND, OR, XOR};

  always_comb begin : nextStateLogic
    nextState = state;
    case (state)
      FETCH_ADDR:
        if (ale)
          nextState = FETCH_ACCESS;  // Idles one cycle after reset to raise ale
      FETCH_ACCESS:
        if (nWait)
          nextState = EXECUTE;
      EXECUTE:
        case (opcode)
          ADD, SUB, AND, OR, XOR, MOVI, BRZ, JMP: nextState = FETCH_ADDR;
          LOAD, STORE:                            nextState = MEM_ADDR;
          default:                                nextState = HALTED;
        endcase
      MEM_ADDR:
        nextState = MEM_ACCESS;
      MEM_ACCESS:
        if (nWait)
          nextState = FETCH_ADDR;
      HALTED:
        nextState = HALTED;
      default:
        nextState = HALTED;
    endcase
  end

  always_comb begin : datapathControls
    aluFunction = ALU_PASSB;
    op2Sel      = 1'b0;
    irWe        = 1'b0;
    pcIncrement = 1'b0;
    pcLoad      = 1'b0;
    regWe       = 1'b0;
    wdSel       = 1'b0;
    flagWe      = 1'b0;
    addrSel     = 1'b0;
    busDataSel  = 1'b0;
    case (state)
      FETCH_ACCESS: begin
        irWe        = nWait;  // Instruction word taken at completion
        pcIncrement = nWait;
      end
      EXECUTE: begin
        case (opcode)
          ADD:     aluFunction = ALU_ADD;
          SUB:     aluFunction = ALU_SUB;
          AND:     aluFunction = ALU_AND;
          OR:      aluFunction = ALU_OR;
          XOR:     aluFunction = ALU_XOR;
          default: aluFunction = ALU_PASSB;
        endcase
        op2Sel = (opcode == MOVI);
        regWe  = isRegisterOp || (opcode == MOVI);
        flagWe = isRegisterOp;
        pcLoad = (opcode == JMP) || ((opcode == BRZ) && zeroFlag);
      end
      MEM_ADDR:
        addrSel = 1'b1;
      MEM_ACCESS: begin
        addrSel    = 1'b1;
        busDataSel = (opcode == STORE);
        wdSel      = 1'b1;
        regWe      = nWait && (opcode == LOAD);
      end
      default: begin
      end
    endcase
  end

  // Strobes are registered from the next state so they line up with it
  always_ff @(posedge Clock) begin : stateAndStrobes
    if (reset) begin
      state <= FETCH_ADDR;
      ale   <= 1'b0;
      nME   <= 1'b1;
      nOE   <= 1'b1;
      rnW   <= 1'b1;
    end else begin
      state <= nextState;
      ale   <= (nextState == FETCH_ADDR) || (nextState == MEM_ADDR);
      nME   <= !((nextState == FETCH_ACCESS) || (nextState == MEM_ACCESS));
      nOE   <= !((nextState == FETCH_ACCESS) ||
                 ((nextState == MEM_ACCESS) && (opcode == LOAD)));
      rnW   <= !((nextState == MEM_ACCESS) && (opcode == STORE));
    end
  end

endmodule

`default_nettype wire

//--- datapath.sv
// Datapath with instruction and flag registers, operand, writeback and bus muxes
`default_nettype none
`timescale 1ns/100ps

module datapath #(
  parameter int                   WordWidth    = 16,
  parameter logic [WordWidth-1:0] ResetAddress = '0
) (
  input  logic                 Clock,
  input  logic                 reset,
  input  cpuPkg::aluFunction_t aluFunction,
  input  logic                 op2Sel,       // 1 selects immediate
  input  logic                 irWe,
  input  logic                 pcIncrement,
  input  logic                 pcLoad,
  input  logic                 regWe,
  input  logic                 wdSel,        // 1 selects dataIn
  input  logic                 flagWe,
  input  logic                 addrSel,      // 1 puts rs on the bus
  input  logic                 busDataSel,   // 1 puts rd data on the bus
  input  logic [WordWidth-1:0] dataIn,
  output cpuPkg::opcode_t      opcode,
  output logic                 zeroFlag,
  output logic [WordWidth-1:0] dataOut
);

  import cpuPkg::*;

  logic [WordWidth-1:0]      instruction;
  logic [WordWidth-1:0]      pc;
  logic [WordWidth-1:0]      rdData;
  logic [WordWidth-1:0]      rsData;
  logic [WordWidth-1:0]      operandB;
  logic [WordWidth-1:0]      aluResult;
  logic [WordWidth-1:0]      writeData;
  logic [WordWidth-1:0]      busAddress;
  logic [3:0]                aluFlags;
  logic [3:0]                flagReg;
  logic [REG_ADDR_WIDTH-1:0] rdIndex;
  logic [REG_ADDR_WIDTH-1:0] rsIndex;
  logic [5:0]                immediate;

  // Instruction register holds HALT out of reset
  always_ff @(posedge Clock) begin
    if (reset) begin
      instruction <= '0;
      flagReg     <= '0;
    end else begin
      if (irWe)
        instruction <= dataIn;
      if (flagWe)
        flagReg <= aluFlags;
    end
  end

  assign opcode    = opcode_t'(instruction[15:8]);
  assign rdIndex   = instruction[7:6];
  assign rsIndex   = instruction[5:4];
  assign immediate = instruction[5:0];
  assign zeroFlag  = flagReg[3];

  assign operandB   = op2Sel ? {{(WordWidth-6){1'b0}}, immediate} : rsData;
  assign writeData  = wdSel ? dataIn : aluResult;
  assign busAddress = addrSel ? rsData : pc;
  assign dataOut    = busDataSel ? rdData : busAddress;  // Multiplexed address/data

  programCounter #(
    .WordWidth    (WordWidth),
    .ResetAddress (ResetAddress)
  ) u_programCounter (
    .Clock       (Clock),
    .reset       (reset),
    .pcIncrement (pcIncrement),
    .pcLoad      (pcLoad),
    .offset      (immediate),
    .pc          (pc)
  );

  registerFile #(
    .WordWidth (WordWidth)
  ) u_registerFile (
    .Clock       (Clock),
    .reset       (reset),
    .writeEnable (regWe),
    .writeIndex  (rdIndex),
    .writeData   (writeData),
    .readIndexA  (rdIndex),
    .readIndexB  (rsIndex),
    .readDataA   (rdData),
    .readDataB   (rsData)
  );

  alu #(
    .WordWidth (WordWidth)
  ) u_alu (
    .aluFunction (aluFunction),
    .operandA    (rdData),
    .operandB    (operandB),
    .result      (aluResult),
    .flags       (aluFlags)
  );

endmodule

`default_nettype wire

//--- registerFile.sv
// Four-entry register file, two combinational read ports and one write port
`default_nettype none
`timescale 1ns/100ps

module registerFile #(
  parameter int WordWidth = 16
) (
  input  logic                              Clock,
  input  logic                              reset,
  input  logic                              writeEnable,
  input  logic [cpuPkg::REG_ADDR_WIDTH-1:0] writeIndex,
  input  logic [WordWidth-1:0]              writeData,
  input  logic [cpuPkg::REG_ADDR_WIDTH-1:0] readIndexA,
  input  logic [cpuPkg::REG_ADDR_WIDTH-1:0] readIndexB,
  output logic [WordWidth-1:0]              readDataA,
  output logic [WordWidth-1:0]              readDataB
);

  import cpuPkg::*;

  localparam int RegCount = 2 ** REG_ADDR_WIDTH;

  logic [WordWidth-1:0] registers [RegCount];

  always_ff @(posedge Clock) begin
    if (reset) begin
      registers <= '{default: '0};
    end else if (writeEnable) begin
      registers[writeIndex] <= writeData;
    end
  end

  assign readDataA = registers[readIndexA];  // rd
  assign readDataB = registers[readIndexB];  // rs

endmodule

`default_nettype wire

//--- alu.sv
// Combinational ALU with Z/N/C/V flag generation
`default_nettype none
`timescale 1ns/100ps

module alu #(
  parameter int WordWidth = 16
) (
  input  cpuPkg::aluFunction_t aluFunction,
  input  logic [WordWidth-1:0] operandA,
  input  logic [WordWidth-1:0] operandB,
  output logic [WordWidth-1:0] result,
  output logic [3:0]           flags
);

  import cpuPkg::*;

  localparam int Msb = WordWidth - 1;

  logic [WordWidth:0] sum;
  logic [WordWidth:0] difference;
  logic               carry;
  logic               overflow;

  // SUB as A + ~B + 1 so the carry out is the inverted borrow
  assign sum        = {1'b0, operandA} + {1'b0, operandB};
  assign difference = {1'b0, operandA} + {1'b0, ~operandB} + 1'b1;

  always_comb begin
    carry    = 1'b0;
    overflow = 1'b0;
    case (aluFunction)
      ALU_ADD: begin
        result   = sum[Msb:0];
        carry    = sum[WordWidth];
        overflow = (operandA[Msb] == operandB[Msb]) && (result[Msb] != operandA[Msb]);
      end
      ALU_SUB: begin
        result   = difference[Msb:0];
        carry    = difference[WordWidth];
        overflow = (operandA[Msb] != operandB[Msb]) && (result[Msb] != operandA[Msb]);
      end
      ALU_AND: result = operandA & operandB;
      ALU_OR:  result = operandA | operandB;
      ALU_XOR: result = operandA ^ operandB;
      default: result = operandB;   // PASSB for MOVI
    endcase
  end

  assign flags = {(result == '0), result[Msb], carry, overflow};  // Z N C V

endmodule

`default_nettype wire

//--- programCounter.sv
// Program counter with increment and pc-relative branch load
`default_nettype none
`timescale 1ns/100ps

module programCounter #(
  parameter int                   WordWidth    = 16,
  parameter logic [WordWidth-1:0] ResetAddress = '0
) (
  input  logic                 Clock,
  input  logic                 reset,
  input  logic                 pcIncrement,
  input  logic                 pcLoad,
  input  logic [5:0]           offset,
  output logic [WordWidth-1:0] pc
);

  logic [WordWidth-1:0] branchOffset;

  assign branchOffset = {{(WordWidth-6){offset[5]}}, offset};  // Sign extended

  always_ff @(posedge Clock) begin
    if (reset) begin
      pc <= ResetAddress;
    end else if (pcLoad) begin
      pc <= pc + branchOffset;  // Already points past the branch
    end else if (pcIncrement) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- cpuPkg.sv
// Word widths, opcode, ALU function and control state types for the core
`default_nettype none

package cpuPkg;

  localparam int WORD_WIDTH = 16;     // Data, address and instruction
  localparam int REG_ADDR_WIDTH = 2;  // Four registers

  // Instruction opcodes, bits 15:8 of the instruction word
  typedef enum logic [7:0] {
    HALT  = 8'h00,                    // Cleared memory parks the core
    ADD   = 8'h01,
    SUB   = 8'h02,
    AND   = 8'h03,
    OR    = 8'h04,
    XOR   = 8'h05,
    MOVI  = 8'h10,
    LOAD  = 8'h20,
    STORE = 8'h21,
    BRZ   = 8'h30,
    JMP   = 8'h31
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_PASSB = 3'd5                  // Operand B straight through
  } aluFunction_t;

  typedef enum logic [2:0] {
    FETCH_ADDR   = 3'd0,
    FETCH_ACCESS = 3'd1,
    EXECUTE      = 3'd2,
    MEM_ADDR     = 3'd3,
    MEM_ACCESS   = 3'd4,
    HALTED       = 3'd5
  } controlState_t;

endpackage

`default_nettype wire
